//--- ks10_settings.svh
`ifndef KS10_SETTINGS_SVH
`define KS10_SETTINGS_SVH

//////////////////////////////////////////////////
// Data path geometry
//////////////////////////////////////////////////

// Full data path word, bits numbered 0 to 35
`define KS10_DP_WIDTH 36

// Virtual address field, dp bits 18 to 35
`define KS10_ADDR_WIDTH 18

// One AC block number
`define KS10_BLOCK_WIDTH 3

//////////////////////////////////////////////////
// Request buffering
//////////////////////////////////////////////////

// Request queue entries, power of two only
`define KS10_QUEUE_DEPTH 4

`endif

//--- logic/ks10_pkg.sv
`include "ks10_settings.svh"

package ks10_pkg;

   // Microword spec-select field
   // PXCT load and PXCT off share one code, split by specEn10 / specEn20
   typedef enum logic [3:0]
   {
      SPEC_NONE      = 4'd0,
      SPEC_PXCT      = 4'd4,
      SPEC_LOADACBLK = 4'd6
   } specSel_t;

   // Memory operation type from the microword PXCT select
   typedef enum logic [2:0]
   {
      CURRENT    = 3'd0,
      E1         = 3'd1,
      E1D1       = 3'd2,
      D1         = 3'd3,
      BIS_SRC_EA = 3'd4,
      E2         = 3'd5,
      BIS_DST_EA = 3'd6,
      D2         = 3'd7
   } pxctSel_t;

   // One bus request, 21 bits
   typedef struct packed
   {
      logic                          isAc;
      logic                          prev;
      logic                          write;
      logic [0:`KS10_ADDR_WIDTH-1]   addr;
   } memReq_t;

endpackage

//--- logic/pxctContext.sv
`timescale 1ns/100ps
`include "ks10_settings.svh"

module pxctContext
   import ks10_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clken,
   input  logic                          specEn10,
   input  logic                          specEn20,
   input  logic                          specEn40,
   input  specSel_t                      specSel,
   input  pxctSel_t                      memPxctSel,
   input  logic [0:`KS10_DP_WIDTH-1]     dp,
   output logic                          prevEn,
   output logic [0:`KS10_BLOCK_WIDTH-1]  curBlock,
   output logic [0:`KS10_BLOCK_WIDTH-1]  prevBlock
);

   //////////////////////////////////////////////////
   // Spec strobe decode
   //////////////////////////////////////////////////

   logic loadAcBlk;
   logic loadPxct;

   // AC block load on the 40 enable
   assign loadAcBlk = clken & specEn40 & (specSel == SPEC_LOADACBLK);
   // PXCT load on the 10 enable, off qualifier rides on the 20 enable
   assign loadPxct  = clken & specEn10 & (specSel == SPEC_PXCT);

   //////////////////////////////////////////////////
   // AC block register
   //////////////////////////////////////////////////

   // Current block from dp 6..8, previous block from dp 9..11
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         curBlock  <= '0;
         prevBlock <= '0;
      end
      else if (loadAcBlk)
      begin
         curBlock  <= dp[6:8];
         prevBlock <= dp[9:11];
      end
   end

   //////////////////////////////////////////////////
   // PXCT register
   //////////////////////////////////////////////////

   // AC field of the XCT, bit 9 E1, 10 D1, 11 E2, 12 D2
   logic [9:12] pxct;
   logic        pxctEn;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pxct   <= '0;
         pxctEn <= 1'b0;
      end
      else if (loadPxct)
      begin
         pxct   <= dp[9:12];
         // Load and off in the same cycle leaves context disabled
         pxctEn <= ~specEn20;
      end
   end

   //////////////////////////////////////////////////
   // prevEn decode
   //////////////////////////////////////////////////

   // Memory op type picks which AC field bit applies
   always_comb
   begin
      prevEn = 1'b0;
      if (pxctEn)
      begin
         case (memPxctSel)
            CURRENT:    prevEn = 1'b0;
            E1:         prevEn = pxct[9];
            E1D1:       prevEn = pxct[10] & pxct[9];
            D1:         prevEn = pxct[10];
            // Byte instruction source, only with E1 also set
            BIS_SRC_EA: prevEn = pxct[11] & pxct[9];
            E2:         prevEn = pxct[11];
            // Byte instruction destination
            BIS_DST_EA: prevEn = pxct[12] & pxct[9];
            D2:         prevEn = pxct[12];
            default:    prevEn = 1'b0;
         endcase
      end
   end

endmodule

//--- logic/memRequestForm.sv
`timescale 1ns/100ps
`include "ks10_settings.svh"

module memRequestForm
   import ks10_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clken,
   input  logic                          memCycle,
   input  logic                          memWrite,
   input  logic [0:`KS10_DP_WIDTH-1]     dp,
   input  logic                          prevEn,
   input  logic [0:`KS10_BLOCK_WIDTH-1]  curBlock,
   input  logic [0:`KS10_BLOCK_WIDTH-1]  prevBlock,
   input  logic                          full,
   output logic                          push,
   output memReq_t                       pushData,
   output logic                          overflow
);

   // Zero fill above block and AC number in a fast memory address
   localparam int FILL_WIDTH = `KS10_ADDR_WIDTH - `KS10_BLOCK_WIDTH - 4;

   logic [0:`KS10_ADDR_WIDTH-1]   vAddr;
   logic [0:`KS10_ADDR_WIDTH-1]   acAddr;
   logic [0:`KS10_BLOCK_WIDTH-1]  selBlock;
   logic                          acRef;
   logic                          cycle;

   //////////////////////////////////////////////////
   // AC reference mapping
   //////////////////////////////////////////////////

   // Virtual address from the right half of dp
   assign vAddr = dp[18:35];

   // Addresses 0..17 octal hit the ACs
   assign acRef = (vAddr[0:`KS10_ADDR_WIDTH-5] == '0);

   // Previous context uses the previous AC block
   assign selBlock = prevEn ? prevBlock : curBlock;

   // Block times 16 plus AC number
   assign acAddr = {{FILL_WIDTH{1'b0}}, selBlock, vAddr[`KS10_ADDR_WIDTH-4:`KS10_ADDR_WIDTH-1]};

   // Request word
   always_comb
   begin
      pushData.isAc  = acRef;
      pushData.prev  = prevEn;
      pushData.write = memWrite;
      pushData.addr  = acRef ? acAddr : vAddr;
   end

   //////////////////////////////////////////////////
   // Push and overflow
   //////////////////////////////////////////////////

   assign cycle = clken & memCycle;

   // No push into a full queue, the request is lost
   assign push = cycle & ~full;

   // Sticky until reset
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         overflow <= 1'b0;
      else if (cycle & full)
         overflow <= 1'b1;
   end

endmodule

//--- logic/reqQueue.sv
`timescale 1ns/100ps
`include "ks10_settings.svh"

module reqQueue
#(
   parameter type payload_t = logic [7:0]
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      push,
   input  payload_t  pushData,
   input  logic      pop,
   output payload_t  head,
   output logic      notEmpty,
   output logic      full
);

   localparam int DEPTH     = `KS10_QUEUE_DEPTH;
   localparam int PTR_WIDTH = $clog2(DEPTH);

   //////////////////////////////////////////////////
   // Storage and pointers
   //////////////////////////////////////////////////

   payload_t               mem [0:DEPTH-1];
   logic [PTR_WIDTH-1:0]   wrPtr;
   logic [PTR_WIDTH-1:0]   rdPtr;
   // One extra bit to tell full from empty
   logic [PTR_WIDTH:0]     count;
   logic                   doPush;
   logic                   doPop;

   // Status from the count alone
   assign notEmpty = (count != '0);
   assign full     = (count == DEPTH[PTR_WIDTH:0]);

   // Qualified strobes, full check ignores a same cycle pop
   assign doPush = push & ~full;
   assign doPop  = pop & notEmpty;

   // Head entry straight from storage
   assign head = mem[rdPtr];

   // Payload write
   always_ff @(posedge clk)
   begin
      if (doPush)
         mem[wrPtr] <= pushData;
   end

   //////////////////////////////////////////////////
   // Pointer and count update
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else
      begin
         // Pointers wrap on power of two depth
         if (doPush)
            wrPtr <= wrPtr + 1'b1;
         if (doPop)
            rdPtr <= rdPtr + 1'b1;
         // Simultaneous push and pop leaves count alone
         if (doPush & ~doPop)
            count <= count + 1'b1;
         else if (doPop & ~doPush)
            count <= count - 1'b1;
      end
   end

endmodule

//--- logic/pxctMemPath.sv
`timescale 1ns/100ps
`include "ks10_settings.svh"

module pxctMemPath
   import ks10_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clken,
   input  logic                          specEn10,
   input  logic                          specEn20,
   input  logic                          specEn40,
   input  specSel_t                      specSel,
   input  pxctSel_t                      memPxctSel,
   input  logic                          memCycle,
   input  logic                          memWrite,
   input  logic [0:`KS10_DP_WIDTH-1]     dp,
   input  logic                          busReady,
   output logic                          prevEn,
   output logic [0:`KS10_BLOCK_WIDTH-1]  curBlock,
   output logic [0:`KS10_BLOCK_WIDTH-1]  prevBlock,
   output logic                          busValid,
   output logic                          busIsAc,
   output logic                          busPrev,
   output logic                          busWrite,
   output logic [0:`KS10_ADDR_WIDTH-1]   busAddr,
   output logic                          overflow
);

   logic     push;
   logic     full;
   logic     pop;
   memReq_t  pushData;
   memReq_t  head;

   // Context state and prevEn
   pxctContext pxctContext_inst (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .specEn10   (specEn10),
      .specEn20   (specEn20),
      .specEn40   (specEn40),
      .specSel    (specSel),
      .memPxctSel (memPxctSel),
      .dp         (dp),
      .prevEn     (prevEn),
      .curBlock   (curBlock),
      .prevBlock  (prevBlock)
   );

   // Memory cycle to request
   memRequestForm memRequestForm_inst (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .memCycle  (memCycle),
      .memWrite  (memWrite),
      .dp        (dp),
      .prevEn    (prevEn),
      .curBlock  (curBlock),
      .prevBlock (prevBlock),
      .full      (full),
      .push      (push),
      .pushData  (pushData),
      .overflow  (overflow)
   );

   //////////////////////////////////////////////////
   // Bus side
   //////////////////////////////////////////////////

   // Bus takes the head on valid and ready
   assign pop = busValid & busReady;

   reqQueue #(.payload_t(memReq_t)) reqQueue_inst (
      .clk      (clk),
      .rst      (rst),
      .push     (push),
      .pushData (pushData),
      .pop      (pop),
      .head     (head),
      .notEmpty (busValid),
      .full     (full)
   );

   // Head fields onto the bus ports
   assign busIsAc  = head.isAc;
   assign busPrev  = head.prev;
   assign busWrite = head.write;
   assign busAddr  = head.addr;

endmodule

//--- dv/clockGen.sv
`timescale 1ns/100ps

module clockGen
(
   output logic clk,
   output logic rst
);

   // Free running clock, 4 ns period
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Reset held over the first three rising edges
   initial
   begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

//--- dv/pxct_assertions.sv
`timescale 1ns/100ps
`include "ks10_settings.svh"

module pxct_assertions
(
   input logic                         clk,
   input logic                         rst,
   input logic                         busValid,
   input logic                         busReady,
   input logic                         prevEn,
   input logic                         overflow,
   input logic                         busIsAc,
   input logic                         busPrev,
   input logic                         busWrite,
   input logic [0:`KS10_ADDR_WIDTH-1]  busAddr
);

   //////////////////////////////////////////////////
   // Reset, bus hold and sticky overflow
   //////////////////////////////////////////////////

   // Nothing requested and no context while in reset
   resetQuiet: assert property (@(posedge clk) rst |-> (!busValid && !prevEn && !overflow))
      else $error("bus valid, prevEn or overflow high during reset");

   // Stalled bus sees the same head next cycle
   headHeld: assert property (@(posedge clk) disable iff (rst)
      (busValid && !busReady) |=> $stable({busIsAc, busPrev, busWrite, busAddr}))
      else $error("bus head changed while stalled");

   // Overflow only clears on reset
   overflowSticky: assert property (@(posedge clk) disable iff (rst) overflow |=> overflow)
      else $error("overflow fell without reset");

endmodule

//--- dv/pxctTb.sv
`timescale 1ns/100ps
`include "ks10_settings.svh"

module pxctTb
   import ks10_pkg::*;
();

   // Row operations and bus ready modes
   localparam logic [2:0] OP_IDLE  = 3'd0;
   localparam logic [2:0] OP_BLK   = 3'd1;
   localparam logic [2:0] OP_PXCT  = 3'd2;
   localparam logic [2:0] OP_RPXCT = 3'd3;
   localparam logic [2:0] OP_OFF   = 3'd4;
   localparam logic [2:0] OP_MEM   = 3'd5;
   localparam logic [2:0] OP_DRAIN = 3'd6;
   localparam logic [1:0] RDY_LOW  = 2'd0;
   localparam logic [1:0] RDY_HI   = 2'd1;
   localparam logic [1:0] RDY_RAND = 2'd2;
   localparam int NROWS       = 34;
   localparam int CYCLE_LIMIT = NROWS * 8 + 100;

   typedef struct packed
   {
      logic [2:0]  op;
      logic [1:0]  rdy;
      logic [0:35] d;
      logic [2:0]  sel;
      logic        wr;
   } row_t;

   localparam row_t IDLE_ROW = '{OP_IDLE, RDY_HI, 36'h0, 3'd0, 1'b0};

   logic clk, rst, clken, specEn10, specEn20, specEn40, memCycle, memWrite, busReady;
   specSel_t                       specSel;
   pxctSel_t                       memPxctSel;
   logic [0:`KS10_DP_WIDTH-1]      dp;
   logic                           prevEn, busValid, busIsAc, busPrev, busWrite, overflow;
   logic [0:`KS10_BLOCK_WIDTH-1]   curBlock, prevBlock;
   logic [0:`KS10_ADDR_WIDTH-1]    busAddr;

   // Reference model state
   logic [0:2]   mCur = '0;
   logic [0:2]   mPrev = '0;
   logic         mE1 = 1'b0;
   logic         mD1 = 1'b0;
   logic         mE2 = 1'b0;
   logic         mD2 = 1'b0;
   logic         mEn = 1'b0;
   logic         mOvf = 1'b0;
   memReq_t      expQ [$];
   logic [31:0]  lcgState = 32'h95ab_0cc1;
   int           cycles = 0;

   //////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////

   row_t stim [0:NROWS-1] = '{
      // PXCT patterns each followed by a sweep of all selects
      '{OP_PXCT,  RDY_HI, 36'h007800000, 3'd0, 1'b0},
      '{OP_PXCT,  RDY_HI, 36'h004000000, 3'd0, 1'b0},
      '{OP_PXCT,  RDY_HI, 36'h002800000, 3'd0, 1'b0},
      '{OP_PXCT,  RDY_HI, 36'h001000000, 3'd0, 1'b0},
      '{OP_RPXCT, RDY_HI, 36'h000000000, 3'd0, 1'b0},
      '{OP_RPXCT, RDY_HI, 36'h000000000, 3'd0, 1'b0},
      '{OP_RPXCT, RDY_HI, 36'h000000000, 3'd0, 1'b0},
      '{OP_OFF,   RDY_HI, 36'h007800000, 3'd0, 1'b0},
      // Blocks 5 and 3 with E1 and D1 on for AC and high references
      '{OP_BLK,   RDY_HI, 36'h02b000000, 3'd0, 1'b0},
      '{OP_PXCT,  RDY_HI, 36'h006000000, 3'd0, 1'b0},
      '{OP_MEM,   RDY_HI, 36'h000000005, 3'd1, 1'b0},
      '{OP_MEM,   RDY_HI, 36'h00000000f, 3'd0, 1'b1},
      '{OP_MEM,   RDY_HI, 36'h000001234, 3'd3, 1'b1},
      '{OP_MEM,   RDY_HI, 36'h000000010, 3'd5, 1'b0},
      '{OP_DRAIN, RDY_HI, 36'h000000000, 3'd0, 1'b0},
      '{OP_BLK,   RDY_HI, 36'h01c000000, 3'd0, 1'b0},
      // Burst under a random ready pattern
      '{OP_MEM,   RDY_RAND, 36'h000000003, 3'd2, 1'b0},
      '{OP_IDLE,  RDY_RAND, 36'h000000000, 3'd0, 1'b0},
      '{OP_MEM,   RDY_RAND, 36'h000002000, 3'd4, 1'b1},
      '{OP_MEM,   RDY_RAND, 36'h00000000e, 3'd0, 1'b0},
      '{OP_IDLE,  RDY_RAND, 36'h000000000, 3'd0, 1'b0},
      '{OP_MEM,   RDY_RAND, 36'h00003fff0, 3'd7, 1'b1},
      '{OP_MEM,   RDY_RAND, 36'h000000009, 3'd6, 1'b1},
      '{OP_IDLE,  RDY_RAND, 36'h000000000, 3'd0, 1'b0},
      '{OP_MEM,   RDY_RAND, 36'h000000001, 3'd1, 1'b0},
      '{OP_IDLE,  RDY_RAND, 36'h000000000, 3'd0, 1'b0},
      '{OP_DRAIN, RDY_HI,   36'h000000000, 3'd0, 1'b0},
      // Fifth request into a stalled bus overflows
      '{OP_MEM,   RDY_LOW, 36'h000000002, 3'd1, 1'b0},
      '{OP_MEM,   RDY_LOW, 36'h000000100, 3'd0, 1'b1},
      '{OP_MEM,   RDY_LOW, 36'h000000007, 3'd2, 1'b0},
      '{OP_MEM,   RDY_LOW, 36'h000000040, 3'd3, 1'b1},
      '{OP_MEM,   RDY_LOW, 36'h000000004, 3'd1, 1'b1},
      '{OP_IDLE,  RDY_LOW, 36'h000000000, 3'd0, 1'b0},
      '{OP_DRAIN, RDY_HI,  36'h000000000, 3'd0, 1'b0}
   };

   clockGen clockGen_inst (.clk(clk), .rst(rst));

   pxctMemPath pxctMemPath_inst (.*);

   bind pxctMemPath pxct_assertions pxct_assertions_inst (.*);

   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Select rule over the model's PXCT bits
   function automatic logic expectedPrev(input logic [2:0] sel);
      logic p;
      case (sel)
         3'd1:    p = mE1;
         3'd2:    p = mD1 & mE1;
         3'd3:    p = mD1;
         3'd4:    p = mE2 & mE1;
         3'd5:    p = mE2;
         3'd6:    p = mD2 & mE1;
         3'd7:    p = mD2;
         default: p = 1'b0;
      endcase
      return p & mEn;
   endfunction

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic checkValue(input string name, input logic [35:0] got, input logic [35:0] exp);
      assert (got == exp)
      else stopRun($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   //////////////////////////////////////////////////
   // Checks at the falling edge before the model update
   //////////////////////////////////////////////////

   task automatic checkAndUpdate();
      memReq_t      req;
      logic         ep;
      logic         full;
      logic [0:17]  addr;
      logic [0:2]   blk;
      ep = expectedPrev(memPxctSel);
      checkValue("prevEn", 36'(prevEn), 36'(ep));
      checkValue("curBlock", 36'(curBlock), 36'(mCur));
      checkValue("prevBlock", 36'(prevBlock), 36'(mPrev));
      checkValue("overflow", 36'(overflow), 36'(mOvf));
      checkValue("busValid", 36'(busValid), 36'(expQ.size() != 0));
      if (busValid && expQ.size() != 0)
      begin
         checkValue("busIsAc", 36'(busIsAc), 36'(expQ[0].isAc));
         checkValue("busPrev", 36'(busPrev), 36'(expQ[0].prev));
         checkValue("busWrite", 36'(busWrite), 36'(expQ[0].write));
         checkValue("busAddr", 36'(busAddr), 36'(expQ[0].addr));
      end
      // Full is judged before this edge's pop
      full = (expQ.size() == `KS10_QUEUE_DEPTH);
      if (busReady && expQ.size() != 0)
         void'(expQ.pop_front());
      if (clken && memCycle)
      begin
         addr      = dp[18:35];
         blk       = ep ? mPrev : mCur;
         req.isAc  = (addr < 18'd16);
         req.prev  = ep;
         req.write = memWrite;
         // Fast memory address is block times 16 plus AC number
         req.addr  = req.isAc ? ({15'd0, blk} * 18'd16 + {14'd0, addr[14:17]}) : addr;
         if (full)
            mOvf = 1'b1;
         else
            expQ.push_back(req);
      end
      if (clken && specEn40)
      begin
         mCur  = dp[6:8];
         mPrev = dp[9:11];
      end
      if (clken && specEn10)
      begin
         {mE1, mD1, mE2, mD2} = dp[9:12];
         mEn = ~specEn20;
      end
   endtask

   // One clock of stimulus driven on the rising edge
   task automatic step(input row_t r);
      logic [31:0] rnd;
      logic        pxctOp;
      rnd    = nextRandom();
      pxctOp = (r.op == OP_PXCT) || (r.op == OP_RPXCT) || (r.op == OP_OFF);
      @(posedge clk);
      clken      <= 1'b1;
      specEn10   <= pxctOp;
      specEn20   <= (r.op == OP_OFF);
      specEn40   <= (r.op == OP_BLK);
      specSel    <= (r.op == OP_BLK) ? SPEC_LOADACBLK : (pxctOp ? SPEC_PXCT : SPEC_NONE);
      memCycle   <= (r.op == OP_MEM);
      memWrite   <= r.wr;
      memPxctSel <= pxctSel_t'(r.sel);
      dp         <= r.d;
      // Random mode keeps the bus ready about three cycles in four
      busReady   <= (r.rdy == RDY_RAND) ? (rnd[16] | rnd[24]) : r.rdy[0];
      @(negedge clk);
      checkAndUpdate();
   endtask

   // All eight selects with no request and the bus ready
   task automatic sweepSelects();
      for (int s = 0; s < 8; s++)
         step('{OP_IDLE, RDY_HI, 36'h0, s[2:0], 1'b0});
   endtask

   task automatic drain();
      while (expQ.size() != 0)
         step(IDLE_ROW);
      // Confirm the queue reads empty
      step(IDLE_ROW);
   endtask

   // Run limit
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT)
         stopRun("Timeout: cycle limit reached before the test sequence completed");
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      row_t        r;
      logic [31:0] rnd;
      clken      = 1'b0;
      specEn10   = 1'b0;
      specEn20   = 1'b0;
      specEn40   = 1'b0;
      specSel    = SPEC_NONE;
      // Select that reads the E1 bit while in reset
      memPxctSel = E1;
      memCycle   = 1'b0;
      memWrite   = 1'b0;
      dp         = '0;
      busReady   = 1'b0;
      @(negedge rst);
      // Reset context seen under every select
      sweepSelects();
      for (int i = 0; i < NROWS; i++)
      begin
         r = stim[i];
         if (r.op == OP_RPXCT)
         begin
            rnd         = nextRandom();
            r.d[9:12]   = rnd[27:24];
         end
         if (r.op == OP_DRAIN)
            drain();
         else
            step(r);
         // Every PXCT load gets a sweep of all eight selects
         if (r.op == OP_PXCT || r.op == OP_RPXCT || r.op == OP_OFF)
            sweepSelects();
      end
      drain();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- tb.f
+incdir+.
logic/ks10_pkg.sv
logic/pxctContext.sv
logic/memRequestForm.sv
logic/reqQueue.sv
logic/pxctMemPath.sv
dv/clockGen.sv
dv/pxct_assertions.sv
dv/pxctTb.sv

//--- Makefile
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module pxctTb

sim:
	verilator --binary --assert -j 0 -f tb.f --top-module pxctTb -Mdir $(OBJ_DIR) -o pxctSim
	./$(OBJ_DIR)/pxctSim

clean:
	rm -rf $(OBJ_DIR)
